//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sources.f
verilog/cpuPkg.sv
verilog/fetchUnit.sv
verilog/cycleSequencer.sv
verilog/decodeRegs.sv
verilog/execUnit.sv
verilog/memCommit.sv
verilog/cpuCore.sv
test/clockGen.sv
test/cpuCore_properties.sv
test/cpuChecker.sv
test/cpuTb.sv

//--- test/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    input  logic resetReq,
    output logic clk,
    output logic reset_n
);

    int holdCount;

    initial begin
        clk       = 1'b0;
        reset_n   = 1'b0;
        holdCount = 5;
    end

    always #20 clk = ~clk; // 40 ns period

    // Reset held for 5 rising edges, restarted by resetReq
    always @(negedge clk) begin
        if (resetReq) begin
            reset_n   <= 1'b0;
            holdCount <= 5;
        end else if (holdCount > 1) begin
            holdCount <= holdCount - 1;
        end else begin
            reset_n   <= 1'b1;
            holdCount <= 0;
        end
    end

endmodule

//--- test/cpuChecker.sv
`timescale 1ns/1ps

module cpuChecker import cpuPkg::*; #(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        start,
    input  logic        done,
    input  int          testId,
    input  logic [31:0] imem [0:255],
    input  logic [31:0] dmemInit [0:255],
    input  logic        iValid,
    input  cpuPkg::iReq iReq,
    input  logic        dValid,
    input  logic        dReady,
    input  cpuPkg::dReq dReq,
    input  logic        halted,
    input  logic [31:0] haltPc,
    output int          testsRun,
    output int          testsFailed,
    output int          errorCount
);

    cpuPkg::dReq expQ [$];
    logic [31:0] expHaltPc;
    int          testErrors;
    int          seenCount;
    logic        resetLowBefore;
    logic        firstFetch;

    initial begin
        testsRun    = 0;
        testsFailed = 0;
        errorCount  = 0;
        testErrors  = 0;
        seenCount   = 0;
    end

    function automatic string testName(input int id);
        case (id)
            0: return "ALU operations";
            1: return "special registers";
            2: return "loads and dereference forms";
            3: return "jumps";
            4: return "halt";
            default: return "reset in mid program";
        endcase
    endfunction

    // Opcode rules taken straight from the instruction set table
    function automatic logic [31:0] aluRef(input int op, input logic [31:0] a, input logic [31:0] b);
        case (op)
            0: return a | b;
            1: return a & b;
            2: return a + b;
            3: return a * b;
            5: return (b >= 32) ? 32'h0 : a << b[4:0];
            6: return {32{$signed(a) < $signed(b)}};
            7: return {32{a == b}};
            8: return {32{$signed(a) > $signed(b)}};
            9: return a & ~b;
            10: return a ^ b;
            11: return a - b;
            12: return a ^ ~b;
            13: return (b >= 32) ? 32'h0 : a >> b[4:0];
            14: return {32{a != b}};
            default: return 32'h0;
        endcase
    endfunction

    // Architectural model, runs the whole program and queues its data transfers
    function automatic void buildExpected();
        logic [31:0] regs [16];
        logic [31:0] mem [256];
        logic [31:0] pcM;
        logic [31:0] insn;
        logic [31:0] imm;
        logic [31:0] rhsM;
        logic [31:0] result;
        insnFields   f;
        int          steps;
        for (int i = 0; i < 16; i++) regs[i] = '0;
        for (int i = 0; i < 256; i++) mem[i] = dmemInit[i];
        expQ.delete();
        expHaltPc = 32'hFFFF_FFFF;
        pcM       = RESET_VECTOR;
        steps     = 0;
        while (steps < 1000) begin
            insn = imem[pcM[7:0]];
            if (insn == 32'hFFFF_FFFF) begin
                expHaltPc = pcM;
                break;
            end
            f        = insnFields'(insn);
            regs[0]  = '0;
            regs[15] = pcM + 1; // r15 reads the next address
            imm      = {{20{f.imm[11]}}, f.imm};
            if (f.typeBit) rhsM = aluRef(int'(f.op), regs[f.x], imm) + regs[f.y];
            else           rhsM = aluRef(int'(f.op), regs[f.x], regs[f.y]) + imm;
            result = rhsM;
            if (f.deref && !f.store) begin
                expQ.push_back('{addr: rhsM, wData: regs[f.z], write: 1'b0});
                result = mem[rhsM[7:0]];
            end else if (f.store && !f.deref) begin
                expQ.push_back('{addr: regs[f.z], wData: rhsM, write: 1'b1});
                mem[regs[f.z][7:0]] = rhsM;
            end else if (f.store) begin
                expQ.push_back('{addr: rhsM, wData: regs[f.z], write: 1'b1});
                mem[rhsM[7:0]] = regs[f.z];
            end
            if (!f.store && f.z == 4'd15) begin
                pcM = result;
            end else begin
                if (!f.store) regs[f.z] = result;
                pcM = pcM + 1;
            end
            steps++;
        end
    endfunction

    task automatic noteError();
        testErrors++;
        errorCount++;
    endtask

    always @(posedge clk) begin
        resetLowBefore <= !reset_n;
        if (!reset_n) firstFetch <= 1'b1;
        if (resetLowBefore && !reset_n && (iValid || dValid)) begin
            $display("Bus request valid while reset is held");
            noteError();
        end
        if (reset_n && firstFetch && iValid) begin
            firstFetch <= 1'b0;
            if (iReq.addr != RESET_VECTOR) begin
                $display("[FAIL] iReq.addr expected %h got %h", RESET_VECTOR, iReq.addr);
                noteError();
            end
        end
    end

    // Compares every data transfer with the model's list
    always @(posedge clk) begin
        cpuPkg::dReq exp;
        if (start) begin
            buildExpected();
            seenCount <= 0;
        end else if (!reset_n) begin
            expQ.delete();
        end else if (dValid && dReady) begin
            seenCount <= seenCount + 1;
            if (expQ.size() == 0) begin
                $display("Unexpected data transfer to address %h", dReq.addr);
                noteError();
            end else begin
                exp = expQ.pop_front();
                if (dReq.write != exp.write) begin
                    $display("[FAIL] dReq.write expected %h got %h", exp.write, dReq.write);
                    noteError();
                end
                if (dReq.addr != exp.addr) begin
                    $display("[FAIL] dReq.addr expected %h got %h", exp.addr, dReq.addr);
                    noteError();
                end
                if (exp.write && dReq.wData != exp.wData) begin
                    $display("[FAIL] dReq.wData expected %h got %h", exp.wData, dReq.wData);
                    noteError();
                end
            end
        end
        if (done) begin
            if (expQ.size() != 0) begin
                $display("Missing %0d expected data transfers", expQ.size());
                noteError();
            end
            if (!halted) begin
                $display("Core did not halt at the end of the program");
                noteError();
            end else if (haltPc != expHaltPc) begin
                $display("[FAIL] haltPc expected %h got %h", expHaltPc, haltPc);
                noteError();
            end
            $display("Test %0d %s: %0d transfers, %0d errors", testId, testName(testId),
                     seenCount, testErrors);
            testsRun++;
            if (testErrors != 0) testsFailed++;
            testErrors = 0;
        end
    end

endmodule

//--- test/cpuCore_properties.sv
`timescale 1ns/1ps

module cpuCoreProperties import cpuPkg::*; (
    input logic        clk,
    input logic        reset_n,
    input logic        iValid,
    input logic        iReady,
    input cpuPkg::iReq iReq,
    input logic        dValid,
    input logic        dReady,
    input cpuPkg::dReq dReq,
    input logic        halted
);

    iRequestHeld: assert property (@(posedge clk) disable iff (!reset_n)
        iValid && !iReady |=> iValid && $stable(iReq))
        else $error("Instruction request dropped or changed before iReady");

    dRequestHeld: assert property (@(posedge clk) disable iff (!reset_n)
        dValid && !dReady |=> dValid && $stable(dReq))
        else $error("Data request dropped or changed before dReady");

    haltSticky: assert property (@(posedge clk) disable iff (!reset_n)
        halted |=> halted)
        else $error("Halt released without reset");

    haltQuiet: assert property (@(posedge clk) disable iff (!reset_n)
        halted |-> !iValid && !dValid)
        else $error("Bus request issued while halted");

endmodule

bind cpuCore cpuCoreProperties props (
    .clk(clk), .reset_n(reset_n), .iValid(iValid), .iReady(iReady), .iReq(iReq),
    .dValid(dValid), .dReady(dReady), .dReq(dReq), .halted(halted));

//--- test/cpuTb.sv
`timescale 1ns/1ps

module cpuTb import cpuPkg::*;;

    localparam logic [31:0] START_ADDR = 32'h0000_0000;

    logic        clk, reset_n, resetReq;
    logic        iReady, dReady, iValid, dValid, halted;
    logic [31:0] iData, dRdata, haltPc;
    cpuPkg::iReq iReq;
    cpuPkg::dReq dReq;
    logic        start, done;
    int          testId, testsRun, testsFailed, errorCount;
    logic [31:0] imem [0:255];
    logic [31:0] dmemInit [0:255];
    logic [31:0] dmem [0:255];
    int          progLen;
    int          seed = 52786;
    int          iWait, dWait;
    logic        iBusy, dBusy;
    logic        running;
    int          runLimit;
    int          runCycles;

    clockGen clkGen (.resetReq(resetReq), .clk(clk), .reset_n(reset_n));

    cpuCore #(.RESET_VECTOR(START_ADDR)) dut (
        .clk(clk), .reset_n(reset_n), .iReady(iReady), .iData(iData), .dReady(dReady),
        .dRdata(dRdata), .iReq(iReq), .iValid(iValid), .dReq(dReq), .dValid(dValid),
        .halted(halted), .haltPc(haltPc));

    cpuChecker #(.RESET_VECTOR(START_ADDR)) checkU (
        .clk(clk), .reset_n(reset_n), .start(start), .done(done), .testId(testId),
        .imem(imem), .dmemInit(dmemInit), .iValid(iValid), .iReq(iReq), .dValid(dValid),
        .dReady(dReady), .dReq(dReq), .halted(halted), .haltPc(haltPc),
        .testsRun(testsRun), .testsFailed(testsFailed), .errorCount(errorCount));

    // Memory models with 0 to 3 random wait states per request
    always @(negedge clk) begin
        if (!reset_n) begin
            iReady <= 1'b0;
            dReady <= 1'b0;
            iBusy  = 1'b0;
            dBusy  = 1'b0;
        end else begin
            if (iReady) begin
                iReady <= 1'b0;
                iBusy  = 1'b0;
            end else if (iValid) begin
                if (!iBusy) begin
                    iBusy = 1'b1;
                    iWait = $random(seed) & 3;
                end
                if (iWait == 0) begin
                    iReady <= 1'b1;
                    iData  <= imem[iReq.addr[7:0]];
                end else iWait--;
            end
            if (dReady) begin
                dReady <= 1'b0;
                dBusy  = 1'b0;
            end else if (dValid) begin
                if (!dBusy) begin
                    dBusy = 1'b1;
                    dWait = $random(seed) & 3;
                end
                if (dWait == 0) begin
                    dReady <= 1'b1;
                    if (dReq.write) dmem[dReq.addr[7:0]] = dReq.wData;
                    else dRdata <= dmem[dReq.addr[7:0]];
                end else dWait--;
            end
        end
    end

    // Ends the run when a program does not halt in time
    always @(negedge clk) begin
        if (!running) begin
            runCycles <= 0;
        end else if (runCycles >= runLimit) begin
            $display("Timeout: program %0d did not halt within %0d cycles", testId, runLimit);
            $display("Simulation failed");
            $finish;
        end else begin
            runCycles <= runCycles + 1;
        end
    end

    function automatic logic [31:0] encode(input int t, input int s, input int d, input int z,
                                           input int x, input int y, input int op,
                                           input int imm);
        return {1'b0, t[0], s[0], d[0], z[3:0], x[3:0], y[3:0], op[3:0], imm[11:0]};
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[progLen] = word;
        progLen++;
    endtask

    task automatic clearImages();
        progLen = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i]     = 32'hFFFF_FFFF; // Runaway fetch halts
            dmemInit[i] = (i * 32'h9E37_79B9) ^ {24'h0, i[7:0]};
        end
    endtask

    task automatic restartCore();
        resetReq <= 1'b1;
        @(negedge clk);
        resetReq <= 1'b0;
        @(negedge clk);
        for (int i = 0; i < 256; i++) dmem[i] = dmemInit[i];
        while (!reset_n) @(negedge clk);
        start <= 1'b1;
        @(negedge clk);
        start <= 1'b0;
    endtask

    task automatic runProgram(input int id, input int interruptAt);
        runLimit = 40 * progLen;
        testId   = id;
        restartCore();
        if (interruptAt > 0) begin
            repeat (interruptAt) @(negedge clk);
            restartCore();
        end
        running <= 1'b1;
        while (!halted) @(negedge clk);
        running <= 1'b0;
        repeat (4) @(negedge clk); // Window for stray requests
        done <= 1'b1;
        @(negedge clk);
        done <= 1'b0;
    endtask

    task automatic buildAlu();
        int y;
        int imm;
        clearImages();
        dmemInit[1] = $random(seed);
        dmemInit[2] = $random(seed);
        dmemInit[3] = $random(seed) & 31;
        emit(encode(0, 0, 1, 1, 0, 0, 0, 1));
        emit(encode(0, 0, 1, 2, 0, 0, 0, 2));
        emit(encode(0, 0, 1, 8, 0, 0, 0, 3));
        for (int op = 0; op < 16; op++) begin
            for (int t = 0; t < 2; t++) begin
                y   = (op == 5 || op == 13) ? 8 : 2; // Small shift amounts
                imm = (t == 1 && y == 8) ? ($random(seed) & 31) : $random(seed);
                emit(encode(t, 0, 0, 3, 1, y, op, imm));
                emit(encode(0, 1, 1, 3, 0, 0, 0, 100 + op * 2 + t));
            end
        end
        emit(32'hFFFF_FFFF);
    endtask

    task automatic buildSpecial();
        clearImages();
        emit(encode(0, 0, 0, 0, 0, 0, 2, 12'h123)); // Dropped write to r0
        emit(encode(0, 1, 1, 0, 0, 0, 0, 50));
        emit(encode(0, 0, 0, 4, 15, 0, 0, 0));
        emit(encode(0, 1, 1, 4, 0, 0, 0, 51));
        emit(encode(0, 0, 0, 5, 0, 0, 0, 60));
        emit(encode(0, 1, 0, 5, 15, 0, 0, 0));
        emit(32'hFFFF_FFFF);
    endtask

    task automatic buildLoads();
        clearImages();
        dmemInit[10] = $random(seed);
        dmemInit[11] = $random(seed);
        emit(encode(0, 0, 1, 6, 0, 0, 0, 10));
        emit(encode(1, 0, 1, 7, 0, 0, 2, 11));
        emit(encode(0, 0, 0, 9, 6, 7, 2, 0));
        emit(encode(0, 1, 1, 9, 0, 0, 0, 70));
        emit(encode(0, 0, 0, 10, 0, 0, 0, 72));
        emit(encode(0, 1, 0, 10, 6, 7, 10, 0));
        emit(encode(0, 0, 1, 11, 0, 0, 0, 72));
        emit(encode(0, 1, 1, 11, 0, 0, 0, 73));
        emit(encode(0, 0, 1, 12, 10, 0, 0, 1));
        emit(encode(0, 1, 1, 12, 0, 0, 0, 74));
        emit(32'hFFFF_FFFF);
    endtask

    task automatic buildJumps();
        clearImages();
        dmemInit[20] = 32'd7;                     // Loaded jump target
        emit(encode(0, 0, 0, 15, 15, 0, 2, 2));  // Skip the next two
        emit(encode(0, 1, 1, 0, 0, 0, 0, 80));
        emit(encode(0, 1, 1, 0, 0, 0, 0, 81));
        emit(encode(0, 1, 1, 15, 0, 0, 0, 82));
        emit(encode(0, 0, 1, 15, 0, 0, 0, 20));
        emit(encode(0, 1, 1, 0, 0, 0, 0, 83));
        emit(encode(0, 1, 1, 0, 0, 0, 0, 84));
        emit(encode(0, 1, 1, 15, 0, 0, 0, 85));
        emit(32'hFFFF_FFFF);
    endtask

    task automatic buildHalt();
        clearImages();
        emit(encode(0, 1, 1, 15, 0, 0, 0, 90));
        emit(32'hFFFF_FFFF);
        emit(encode(0, 1, 1, 15, 0, 0, 0, 91)); // Never fetched
    endtask

    initial begin
        resetReq = 1'b0;
        start    = 1'b0;
        done     = 1'b0;
        running  = 1'b0;
        runLimit = 0;
        testId   = 0;
        iReady   = 1'b0;
        dReady   = 1'b0;
        iData    = '0;
        dRdata   = '0;
        buildAlu();
        runProgram(0, 0);
        buildSpecial();
        runProgram(1, 0);
        buildLoads();
        runProgram(2, 0);
        buildJumps();
        runProgram(3, 0);
        buildHalt();
        runProgram(4, 0);
        buildLoads();
        runProgram(5, 25);
        $display("Summary: %0d tests run, %0d failed, %0d errors", testsRun, testsFailed,
                 errorCount);
        if (testsRun == 6 && testsFailed == 0 && errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verilog/cpuCore.sv
`timescale 1ns/1ps

module cpuCore import cpuPkg::*; #(
    parameter logic [31:0] RESET_VECTOR = cpuPkg::RESET_VECTOR
) (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        iReady,
    input  logic [31:0] iData,
    input  logic        dReady,
    input  logic [31:0] dRdata,
    output cpuPkg::iReq iReq,
    output logic        iValid,
    output cpuPkg::dReq dReq,
    output logic        dValid,
    output logic        halted,
    output logic [31:0] haltPc
);

    corePhase    phase;
    insnFields   fields;
    logic        fetchDone, memDone, illegal;
    logic        wbEn, jumpEn;
    logic [3:0]  wbIndex;
    logic [31:0] insnWord, pc, nextPc;
    logic [31:0] opX, opRight, opAddend, valueZ, rhs;
    logic [31:0] wbData, jumpTarget;

    fetchUnit #(.RESET_VECTOR(RESET_VECTOR)) fetchU (
        .clk(clk), .reset_n(reset_n), .phase(phase), .iReady(iReady), .iData(iData),
        .jumpEn(jumpEn), .jumpTarget(jumpTarget), .iReq(iReq), .iValid(iValid),
        .fetchDone(fetchDone), .insnWord(insnWord), .pc(pc), .nextPc(nextPc));

    cycleSequencer seqU (
        .clk(clk), .reset_n(reset_n), .fetchDone(fetchDone), .memDone(memDone),
        .illegal(illegal), .pc(pc), .phase(phase), .halted(halted), .haltPc(haltPc));

    decodeRegs decodeU (
        .clk(clk), .reset_n(reset_n), .insnWord(insnWord), .nextPc(nextPc),
        .wbEn(wbEn), .wbIndex(wbIndex), .wbData(wbData), .fields(fields),
        .illegal(illegal), .opX(opX), .opRight(opRight), .opAddend(opAddend),
        .valueZ(valueZ));

    execUnit execU (
        .clk(clk), .reset_n(reset_n), .phase(phase), .op(fields.op), .opX(opX),
        .opRight(opRight), .opAddend(opAddend), .rhs(rhs));

    memCommit memU (
        .clk(clk), .reset_n(reset_n), .phase(phase), .fields(fields), .rhs(rhs),
        .valueZ(valueZ), .dReady(dReady), .dRdata(dRdata), .dReq(dReq), .dValid(dValid),
        .memDone(memDone), .wbEn(wbEn), .wbIndex(wbIndex), .wbData(wbData),
        .jumpEn(jumpEn), .jumpTarget(jumpTarget));

endmodule

//--- verilog/cpuPkg.sv
package cpuPkg;

    parameter logic [31:0] RESET_VECTOR = 32'h0000_0000; // First instruction address
    parameter logic [31:0] INSN_NOOP    = 32'h0000_0000; // r0 = r0 | r0 + 0
    parameter logic [3:0]  PC_REG       = 4'd15;
    parameter logic [3:0]  ZERO_REG     = 4'd0;

    typedef enum logic [3:0] {
        orOp,   // X | Y
        andOp,  // X & Y
        addOp,  // X + Y
        mulOp,  // X * Y
        resA,   // Reserved, yields zero
        shlOp,  // X << Y
        ltOp,   // Signed X < Y
        eqOp,   // X == Y
        gtOp,   // Signed X > Y
        andnOp, // X & ~Y
        xorOp,  // X ^ Y
        subOp,  // X - Y
        xnorOp, // X ^ ~Y
        shrOp,  // Logical X >> Y
        neOp,   // X != Y
        resB    // Reserved, yields zero
    } aluOp;

    typedef enum logic [2:0] {
        idle,
        fetch,
        execute,
        memory,
        writeback,
        halted
    } corePhase;

    // Overlays the raw 32-bit instruction word
    typedef struct packed {
        logic        reserved; // Bit 31
        logic        typeBit;  // 1 selects X op imm + Y
        logic        store;
        logic        deref;
        logic [3:0]  z;
        logic [3:0]  x;
        logic [3:0]  y;
        aluOp        op;
        logic [11:0] imm;      // Sign-extended at decode
    } insnFields;

    typedef struct packed {
        logic [31:0] addr;
    } iReq;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wData;
        logic        write;
    } dReq;

endpackage

//--- verilog/cycleSequencer.sv
`timescale 1ns/1ps

module cycleSequencer import cpuPkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        fetchDone,
    input  logic        memDone,
    input  logic        illegal,
    input  logic [31:0] pc,
    output corePhase    phase,
    output logic        halted,
    output logic [31:0] haltPc
);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            phase  <= idle;
            haltPc <= '0;
        end else begin
            case (phase)
                idle:      phase <= fetch;                // One cycle out of reset
                fetch:     if (fetchDone) phase <= execute;
                execute: begin
                    if (illegal) begin
                        phase  <= cpuPkg::halted;
                        haltPc <= pc;                     // pc still names this insn
                    end else begin
                        phase <= memory;
                    end
                end
                memory:    if (memDone) phase <= writeback;
                writeback: phase <= fetch;
                default:   phase <= cpuPkg::halted;       // Stays until reset
            endcase
        end
    end

    assign halted = (phase == cpuPkg::halted);

endmodule

//--- verilog/decodeRegs.sv
`timescale 1ns/1ps

module decodeRegs import cpuPkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  logic [31:0] insnWord,
    input  logic [31:0] nextPc,
    input  logic        wbEn,
    input  logic [3:0]  wbIndex,
    input  logic [31:0] wbData,
    output insnFields   fields,
    output logic        illegal,
    output logic [31:0] opX,
    output logic [31:0] opRight,
    output logic [31:0] opAddend,
    output logic [31:0] valueZ
);

    logic [31:0] regFile [1:14]; // r0 and r15 have no storage
    logic [31:0] immExt;
    logic [31:0] valueY;

    assign fields  = insnFields'(insnWord);
    assign illegal = &insnWord;                        // All ones halts
    assign immExt  = {{20{fields.imm[11]}}, fields.imm};

    function automatic logic [31:0] readReg(input logic [3:0] index);
        if (index == ZERO_REG) begin
            return '0;
        end
        if (index == PC_REG) begin
            return nextPc; // r15 reads as next address
        end
        return regFile[index];
    endfunction

    always_comb begin
        opX    = readReg(fields.x);
        valueY = readReg(fields.y);
        valueZ = readReg(fields.z);
    end

    // Type 1 swaps the roles of Y and the immediate
    always_comb begin
        if (fields.typeBit) begin
            opRight  = immExt;
            opAddend = valueY;
        end else begin
            opRight  = valueY;
            opAddend = immExt;
        end
    end

    // Writes to r0 and r15 are dropped, the jump is handled in fetch
    always_ff @(posedge clk) begin
        if (reset_n && wbEn && wbIndex != ZERO_REG && wbIndex != PC_REG) begin
            regFile[wbIndex] <= wbData;
        end
    end

endmodule

//--- verilog/execUnit.sv
`timescale 1ns/1ps

module execUnit import cpuPkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  corePhase    phase,
    input  aluOp        op,
    input  logic [31:0] opX,
    input  logic [31:0] opRight,
    input  logic [31:0] opAddend,
    output logic [31:0] rhs
);

    logic [31:0] aluOut;
    logic        shiftOver;

    assign shiftOver = |opRight[31:5]; // Amount of 32 or more

    always_comb begin
        case (op)
            orOp:    aluOut = opX | opRight;
            andOp:   aluOut = opX & opRight;
            addOp:   aluOut = opX + opRight;
            mulOp:   aluOut = opX * opRight;            // Low word only
            shlOp:   aluOut = shiftOver ? '0 : opX << opRight[4:0];
            ltOp:    aluOut = {32{$signed(opX) < $signed(opRight)}};
            eqOp:    aluOut = {32{opX == opRight}};
            gtOp:    aluOut = {32{$signed(opX) > $signed(opRight)}};
            andnOp:  aluOut = opX & ~opRight;
            xorOp:   aluOut = opX ^ opRight;
            subOp:   aluOut = opX - opRight;
            xnorOp:  aluOut = opX ^ ~opRight;
            shrOp:   aluOut = shiftOver ? '0 : opX >> opRight[4:0];
            neOp:    aluOut = {32{opX != opRight}};
            default: aluOut = '0;                       // resA and resB
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rhs <= '0;
        end else if (phase == execute) begin
            rhs <= aluOut + opAddend;
        end
    end

endmodule

//--- verilog/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit import cpuPkg::*; #(
    parameter logic [31:0] RESET_VECTOR = cpuPkg::RESET_VECTOR
) (
    input  logic              clk,
    input  logic              reset_n,
    input  corePhase          phase,
    input  logic              iReady,
    input  logic [31:0]       iData,
    input  logic              jumpEn,
    input  logic [31:0]       jumpTarget,
    output cpuPkg::iReq       iReq,
    output logic              iValid,
    output logic              fetchDone,
    output logic [31:0]       insnWord,
    output logic [31:0]       pc,
    output logic [31:0]       nextPc
);

    // Request held for the whole fetch phase, address is the current pc
    assign iValid    = (phase == fetch);
    assign iReq      = '{addr: pc};
    assign fetchDone = iValid && iReady; // Handshake completes the fetch
    assign nextPc    = pc + 32'd1;       // Word addressed

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc       <= RESET_VECTOR;
            insnWord <= INSN_NOOP;
        end else begin
            if (fetchDone) begin
                insnWord <= iData;
            end
            if (phase == writeback) begin
                pc <= jumpEn ? jumpTarget : nextPc; // Write to r15 redirects
            end
        end
    end

endmodule

//--- verilog/memCommit.sv
`timescale 1ns/1ps

module memCommit import cpuPkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  corePhase    phase,
    input  insnFields   fields,
    input  logic [31:0] rhs,
    input  logic [31:0] valueZ,
    input  logic        dReady,
    input  logic [31:0] dRdata,
    output cpuPkg::dReq dReq,
    output logic        dValid,
    output logic        memDone,
    output logic        wbEn,
    output logic [3:0]  wbIndex,
    output logic [31:0] wbData,
    output logic        jumpEn,
    output logic [31:0] jumpTarget
);

    logic        isLoad;
    logic        access;
    logic [31:0] loadWord;
    logic [31:0] result;

    assign isLoad = fields.deref && !fields.store;
    assign access = isLoad || fields.store;

    // Plain store goes to [Z], the deref forms address through rhs
    assign dValid = (phase == memory) && access;
    assign dReq   = '{addr:  (fields.store && !fields.deref) ? valueZ : rhs,
                      wData: fields.deref ? valueZ : rhs,
                      write: fields.store};

    // No bus access means a single memory cycle
    assign memDone = (phase == memory) && (!access || dReady);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            loadWord <= '0;
        end else if (dValid && dReady && isLoad) begin
            loadWord <= dRdata;
        end
    end

    assign result     = fields.deref ? loadWord : rhs;
    assign wbEn       = (phase == writeback) && !fields.store;
    assign wbIndex    = fields.z;
    assign wbData     = result;
    assign jumpEn     = wbEn && (fields.z == PC_REG); // Z of 15 is a jump
    assign jumpTarget = result;

endmodule
